// ==== csr_file.sv ====
`include "trap_config.svh"

module csr_file (
    input  logic                clk,
    input  logic                rst_n,
    input  trap_pkg::csr_wr_t   trap_wr_i,
    input  trap_pkg::csr_wr_t   sw_wr_i,
    input  trap_pkg::csr_addr_t raddr_i,
    output trap_pkg::xlen_t     rdata_o,
    output trap_pkg::xlen_t     mtvec_o,
    output trap_pkg::xlen_t     mepc_o,
    output trap_pkg::xlen_t     mstatus_o
);
    import trap_pkg::*;

    xlen_t mtvec_q;
    xlen_t mepc_q;
    xlen_t mcause_q;
    xlen_t mstatus_q;

    // mtvec and mepc hold word addresses
    function automatic xlen_t word_align(input xlen_t value);
        return {value[`XLEN-1:2], 2'b00};
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
            mstatus_q <= '0;
        end else begin
            if (sw_wr_i.we) begin
                case (sw_wr_i.addr)
                    `CSR_MTVEC:   mtvec_q   <= word_align(sw_wr_i.data);
                    `CSR_MEPC:    mepc_q    <= word_align(sw_wr_i.data);
                    `CSR_MCAUSE:  mcause_q  <= sw_wr_i.data;
                    `CSR_MSTATUS: mstatus_q <= sw_wr_i.data;
                    default: ;
                endcase
            end
            // trap write comes last and wins on the same csr
            if (trap_wr_i.we) begin
                case (trap_wr_i.addr)
                    `CSR_MTVEC:   mtvec_q   <= word_align(trap_wr_i.data);
                    `CSR_MEPC:    mepc_q    <= word_align(trap_wr_i.data);
                    `CSR_MCAUSE:  mcause_q  <= trap_wr_i.data;
                    `CSR_MSTATUS: mstatus_q <= trap_wr_i.data;
                    default: ;
                endcase
            end
        end
    end

    // software read port
    always_comb begin
        case (raddr_i)
            `CSR_MTVEC:   rdata_o = mtvec_q;
            `CSR_MEPC:    rdata_o = mepc_q;
            `CSR_MCAUSE:  rdata_o = mcause_q;
            `CSR_MSTATUS: rdata_o = mstatus_q;
            default:      rdata_o = '0;
        endcase
    end

    assign mtvec_o   = mtvec_q;
    assign mepc_o    = mepc_q;
    assign mstatus_o = mstatus_q;

endmodule

// ==== mtimer.sv ====
`include "trap_config.svh"

module mtimer (
    input  logic                clk,
    input  logic                rst_n,
    input  trap_pkg::csr_wr_t   sw_wr_i,
    input  trap_pkg::csr_addr_t raddr_i,
    output trap_pkg::xlen_t     rdata_o,
    output logic                timer_pending_o
);
    import trap_pkg::*;

    xlen_t mtime_q;
    xlen_t mtimecmp_q;
    logic  pending_q;

    // free-running time base
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + xlen_t'(1);
        end
    end

    // compare value, parked at the top so nothing fires after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtimecmp_q <= '1;
        end else if (sw_wr_i.we && (sw_wr_i.addr == `CSR_MTIMECMP)) begin
            mtimecmp_q <= sw_wr_i.data;
        end
    end

    // pending stays up until software moves mtimecmp ahead
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
        end else begin
            pending_q <= (mtime_q >= mtimecmp_q);
        end
    end

    assign timer_pending_o = pending_q;

    // only mtimecmp is visible on the read port
    assign rdata_o = (raddr_i == `CSR_MTIMECMP) ? mtimecmp_q : '0;

endmodule

// ==== src.f ====
+incdir+.
trap_pkg.sv
mtimer.sv
csr_file.sv
trap_ctrl.sv
trap_unit_top.sv
tb_clock.sv
trap_unit_asserts.sv
trap_unit_tb.sv

// ==== tb_clock.sv ====
module tb_clock (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // 100 ns period
    initial begin
        clk_o = 1'b0;
    end

    always #50 clk_o = ~clk_o;

endmodule

// ==== trap_config.svh ====
`ifndef TRAP_CONFIG_SVH
`define TRAP_CONFIG_SVH

// data and address width, fixed by rv32
`define XLEN 32

// width of a csr address
`define CSR_AW 12

// machine csr addresses
`define CSR_MSTATUS  12'h300
`define CSR_MTVEC    12'h305
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342

// custom address for the timer compare register
`define CSR_MTIMECMP 12'h7C0

// exception cause codes
`define CAUSE_EBREAK   32'd3
`define CAUSE_MISALIGN 32'd4
`define CAUSE_ECALL    32'd11

// interrupt bit set, machine timer
`define CAUSE_MTIMER   32'h80000007

// mstatus bit positions
`define MSTATUS_MIE  3
`define MSTATUS_MPIE 7

`endif

// ==== trap_ctrl.sv ====
`include "trap_config.svh"

module trap_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  trap_pkg::ex_status_t ex_status_i,
    input  logic                 timer_pending_i,
    input  trap_pkg::xlen_t      mtvec_i,
    input  trap_pkg::xlen_t      mepc_i,
    input  trap_pkg::xlen_t      mstatus_i,
    output trap_pkg::csr_wr_t    trap_wr_o,
    output trap_pkg::redirect_t  redirect_o,
    output logic                 stall_o
);
    import trap_pkg::*;

    trap_state_e state_q;
    trap_state_e state_d;
    xlen_t       pc_q;
    xlen_t       cause_q;
    xlen_t       cause_d;
    xlen_t       mstatus_new;
    csr_wr_t     wr_d;
    redirect_t   redir_d;
    logic        mie_now;
    logic        irq_take;
    logic        exc_take;
    logic        accept;

    // an mstatus write on its way into the csr file already holds the new MIE
    always_comb begin
        if (trap_wr_o.we && (trap_wr_o.addr == `CSR_MSTATUS)) begin
            mie_now = trap_wr_o.data[`MSTATUS_MIE];
        end else begin
            mie_now = mstatus_i[`MSTATUS_MIE];
        end
    end

    // arbiter, only looked at in IDLE
    assign irq_take = timer_pending_i && mie_now;
    assign exc_take = ex_status_i.ebreak || ex_status_i.ecall || ex_status_i.misalign;
    assign accept   = (state_q == IDLE) && (irq_take || exc_take || ex_status_i.mret);

    // high in the strobe cycle and for the whole sequence
    assign stall_o = (state_q != IDLE) || accept;

    // cause by priority
    always_comb begin
        if (irq_take) begin
            cause_d = `CAUSE_MTIMER;
        end else if (ex_status_i.ebreak) begin
            cause_d = `CAUSE_EBREAK;
        end else if (ex_status_i.ecall) begin
            cause_d = `CAUSE_ECALL;
        end else begin
            cause_d = `CAUSE_MISALIGN;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (irq_take || exc_take) begin
                    state_d = WR_MEPC;
                end else if (ex_status_i.mret) begin
                    state_d = WR_MRET;
                end
            end
            WR_MEPC:    state_d = WR_MCAUSE;
            WR_MCAUSE:  state_d = WR_MSTATUS;
            WR_MSTATUS: state_d = IDLE;
            WR_MRET:    state_d = IDLE;
            default:    state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // trap pc and cause, taken on entry
    always_ff @(posedge clk) begin
        if ((state_q == IDLE) && (state_d == WR_MEPC)) begin
            pc_q    <= ex_status_i.pc;
            cause_q <= cause_d;
        end
    end

    // next csr write and redirect, one per state
    always_comb begin
        wr_d        = '0;
        redir_d     = '0;
        mstatus_new = mstatus_i;
        case (state_q)
            WR_MEPC: begin
                wr_d = '{we: 1'b1, addr: `CSR_MEPC, data: pc_q};
            end
            WR_MCAUSE: begin
                wr_d = '{we: 1'b1, addr: `CSR_MCAUSE, data: cause_q};
            end
            WR_MSTATUS: begin
                // save MIE into MPIE, then mask
                mstatus_new[`MSTATUS_MPIE] = mstatus_i[`MSTATUS_MIE];
                mstatus_new[`MSTATUS_MIE]  = 1'b0;
                wr_d    = '{we: 1'b1, addr: `CSR_MSTATUS, data: mstatus_new};
                redir_d = '{valid: 1'b1, target: mtvec_i};
            end
            WR_MRET: begin
                mstatus_new[`MSTATUS_MIE]  = mstatus_i[`MSTATUS_MPIE];
                mstatus_new[`MSTATUS_MPIE] = 1'b1;
                wr_d    = '{we: 1'b1, addr: `CSR_MSTATUS, data: mstatus_new};
                redir_d = '{valid: 1'b1, target: mepc_i};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            trap_wr_o  <= '0;
            redirect_o <= '0;
        end else begin
            trap_wr_o  <= wr_d;
            redirect_o <= redir_d;
        end
    end

endmodule

// ==== trap_pkg.sv ====
`include "trap_config.svh"

package trap_pkg;

    // data and address word
    typedef logic [`XLEN-1:0] xlen_t;

    // csr address
    typedef logic [`CSR_AW-1:0] csr_addr_t;

    // trap controller states
    typedef enum logic [2:0] {
        IDLE,
        WR_MEPC,
        WR_MCAUSE,
        WR_MSTATUS,
        WR_MRET
    } trap_state_e;

    // report from the execute stage
    // pc is always valid, the rest are one-cycle strobes
    typedef struct packed {
        xlen_t pc;
        logic  ecall;
        logic  ebreak;
        logic  mret;
        logic  misalign;
    } ex_status_t;

    // one csr write, used by the trap path and by software
    typedef struct packed {
        logic      we;
        csr_addr_t addr;
        xlen_t     data;
    } csr_wr_t;

    // fetch redirect
    typedef struct packed {
        logic  valid;
        xlen_t target;
    } redirect_t;

endpackage

// ==== trap_unit_asserts.sv ====
`include "trap_config.svh"

module trap_unit_asserts (
    input logic                clk,
    input logic                rst_n,
    input trap_pkg::csr_wr_t   trap_wr_i,
    input trap_pkg::redirect_t redirect_i,
    input logic                stall_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int assert_fails = 0;

    // a trap write only starts after a stalled cycle
    we_after_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(trap_wr_i.we) |-> $past(stall_i)
    ) else begin
        assert_fails++;
        $error("trap write started without a stall in the previous cycle");
    end

    // redirect is a single-cycle pulse
    redirect_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect_i.valid |=> !redirect_i.valid
    ) else begin
        assert_fails++;
        $error("redirect valid held for more than one cycle");
    end

    // fetch redirect goes out together with the mstatus update
    redirect_with_mstatus: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect_i.valid |-> (trap_wr_i.we && (trap_wr_i.addr == `CSR_MSTATUS))
    ) else begin
        assert_fails++;
        $error("redirect without an mstatus write in the same cycle");
    end

endmodule

bind trap_ctrl trap_unit_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .trap_wr_i  (trap_wr_o),
    .redirect_i (redirect_o),
    .stall_i    (stall_o)
);

// ==== trap_unit_tb.sv ====
`include "trap_config.svh"

module trap_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import trap_pkg::*;

    // strobe order: ecall, ebreak, mret, misalign
    localparam logic [3:0] EV_ECALL    = 4'b1000;
    localparam logic [3:0] EV_EBREAK   = 4'b0100;
    localparam logic [3:0] EV_MRET     = 4'b0010;
    localparam logic [3:0] EV_MISALIGN = 4'b0001;
    localparam xlen_t      MIE_ON      = xlen_t'(1) << `MSTATUS_MIE;
    localparam xlen_t      TVEC        = 32'h0000_1000;

    logic       clk;
    logic       rst_n;
    ex_status_t ex_status;
    csr_wr_t    sw_wr;
    csr_addr_t  csr_raddr;
    xlen_t      csr_rdata;
    logic       stall;
    redirect_t  redirect;
    xlen_t      mtime_model;
    integer     seed;
    int         errors;
    int         assert_fails;

    tb_clock u_clock (
        .clk_o (clk)
    );

    trap_unit_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .ex_status_i (ex_status),
        .sw_wr_i     (sw_wr),
        .csr_raddr_i (csr_raddr),
        .csr_rdata_o (csr_rdata),
        .stall_o     (stall),
        .redirect_o  (redirect)
    );

    // expected mtime, zero after reset and one step per cycle
    always @(posedge clk) begin
        if (!rst_n) begin
            mtime_model <= '0;
        end else begin
            mtime_model <= mtime_model + xlen_t'(1);
        end
    end

    task automatic check_xlen(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
            errors++;
        end
    endtask

    function automatic xlen_t draw_pc();
        return xlen_t'($random(seed)) & 32'hFFFF_FFFC;
    endfunction

    task automatic write_csr(input csr_addr_t addr, input xlen_t data);
        sw_wr = '{we: 1'b1, addr: addr, data: data};
        @(posedge clk);
        #1;
        sw_wr = '0;
    endtask

    // address held for one cycle, data sampled mid-cycle
    task automatic read_csr(input csr_addr_t addr, output xlen_t data);
        csr_raddr = addr;
        @(negedge clk);
        data = csr_rdata;
        @(posedge clk);
        #1;
    endtask

    // one-cycle strobe, stall sampled mid-cycle
    task automatic issue_event(input xlen_t pc, input logic [3:0] ev, output logic stall_seen);
        ex_status.pc = pc;
        {ex_status.ecall, ex_status.ebreak, ex_status.mret, ex_status.misalign} = ev;
        @(negedge clk);
        stall_seen = stall;
        @(posedge clk);
        #1;
        {ex_status.ecall, ex_status.ebreak, ex_status.mret, ex_status.misalign} = 4'b0000;
    endtask

    task automatic wait_redirect(output logic found, output xlen_t target);
        int count;
        count  = 0;
        found  = 1'b0;
        target = '0;
        while (!found && (count < 20)) begin
            @(negedge clk);
            if (redirect.valid) begin
                found  = 1'b1;
                target = redirect.target;
            end
            count++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic expect_redirect(input xlen_t exp_target, input string what);
        logic  found;
        xlen_t target;
        wait_redirect(found, target);
        if (!found) begin
            $display("%0t: no redirect within 20 cycles after %s", $time, what);
            errors++;
        end else begin
            check_xlen("redirect_o.target", exp_target, target);
        end
    endtask

    task automatic expect_no_redirect(input string what);
        logic  found;
        xlen_t target;
        wait_redirect(found, target);
        if (found) begin
            $display("%0t: unexpected redirect to %h after %s", $time, target, what);
            errors++;
        end
    endtask

    task automatic reset_state();
        xlen_t val;
        check_bit("stall_o", 1'b0, stall);
        check_bit("redirect_o.valid", 1'b0, redirect.valid);
        read_csr(`CSR_MTVEC, val);
        check_xlen("mtvec", '0, val);
        read_csr(`CSR_MEPC, val);
        check_xlen("mepc", '0, val);
        read_csr(`CSR_MCAUSE, val);
        check_xlen("mcause", '0, val);
        read_csr(`CSR_MSTATUS, val);
        check_xlen("mstatus", '0, val);
        read_csr(`CSR_MTIMECMP, val);
        check_xlen("mtimecmp", '1, val);
    endtask

    task automatic ecall_trap();
        xlen_t pc;
        xlen_t val;
        logic  stall_seen;
        pc = draw_pc();
        write_csr(`CSR_MTVEC, TVEC);
        write_csr(`CSR_MSTATUS, MIE_ON);
        issue_event(pc, EV_ECALL, stall_seen);
        check_bit("stall_o", 1'b1, stall_seen);
        expect_redirect(TVEC, "ecall");
        read_csr(`CSR_MEPC, val);
        check_xlen("mepc", pc, val);
        read_csr(`CSR_MCAUSE, val);
        check_xlen("mcause", `CAUSE_ECALL, val);
        read_csr(`CSR_MSTATUS, val);
        check_bit("mstatus.MIE", 1'b0, val[`MSTATUS_MIE]);
        check_bit("mstatus.MPIE", 1'b1, val[`MSTATUS_MPIE]);
    endtask

    task automatic cause_priority();
        xlen_t pc;
        xlen_t val;
        logic  stall_seen;
        pc = draw_pc();
        issue_event(pc, EV_EBREAK | EV_ECALL, stall_seen);
        check_bit("stall_o", 1'b1, stall_seen);
        expect_redirect(TVEC, "ebreak with ecall");
        read_csr(`CSR_MCAUSE, val);
        check_xlen("mcause", `CAUSE_EBREAK, val);
        pc = draw_pc();
        issue_event(pc, EV_MISALIGN, stall_seen);
        check_bit("stall_o", 1'b1, stall_seen);
        expect_redirect(TVEC, "misalign");
        read_csr(`CSR_MCAUSE, val);
        check_xlen("mcause", `CAUSE_MISALIGN, val);
        read_csr(`CSR_MEPC, val);
        check_xlen("mepc", pc, val);
    endtask

    task automatic mret_return();
        xlen_t pc;
        xlen_t val;
        logic  stall_seen;
        pc = draw_pc();
        write_csr(`CSR_MSTATUS, MIE_ON);
        issue_event(pc, EV_ECALL, stall_seen);
        expect_redirect(TVEC, "ecall before mret");
        issue_event(pc, EV_MRET, stall_seen);
        check_bit("stall_o", 1'b1, stall_seen);
        expect_redirect(pc, "mret");
        read_csr(`CSR_MSTATUS, val);
        check_bit("mstatus.MIE", 1'b1, val[`MSTATUS_MIE]);
        check_bit("mstatus.MPIE", 1'b1, val[`MSTATUS_MPIE]);
    endtask

    task automatic timer_interrupt();
        xlen_t pc;
        xlen_t val;
        pc = draw_pc();
        ex_status.pc = pc;
        write_csr(`CSR_MSTATUS, MIE_ON);
        write_csr(`CSR_MTIMECMP, mtime_model + xlen_t'(4));
        expect_redirect(TVEC, "timer interrupt");
        read_csr(`CSR_MCAUSE, val);
        check_xlen("mcause", `CAUSE_MTIMER, val);
        read_csr(`CSR_MEPC, val);
        check_xlen("mepc", pc, val);
        // still pending, but masked by the trap
        expect_no_redirect("timer with MIE clear");
    endtask

    task automatic irq_over_ecall();
        xlen_t pc;
        xlen_t pc_late;
        xlen_t val;
        logic  stall_seen;
        pc      = draw_pc();
        pc_late = draw_pc();
        // timer still pending, MIE set races the ecall
        write_csr(`CSR_MSTATUS, MIE_ON);
        issue_event(pc, EV_ECALL, stall_seen);
        check_bit("stall_o", 1'b1, stall_seen);
        issue_event(pc_late, EV_ECALL, stall_seen);
        check_bit("stall_o", 1'b1, stall_seen);
        expect_redirect(TVEC, "timer with ecall");
        expect_no_redirect("ecall during stall");
        read_csr(`CSR_MCAUSE, val);
        check_xlen("mcause", `CAUSE_MTIMER, val);
        read_csr(`CSR_MEPC, val);
        check_xlen("mepc", pc, val);
        write_csr(`CSR_MTIMECMP, '1);
    endtask

    task automatic sw_roundtrip();
        xlen_t val;
        write_csr(`CSR_MTVEC, 32'h0000_2000);
        read_csr(`CSR_MTVEC, val);
        check_xlen("mtvec", 32'h0000_2000, val);
        write_csr(`CSR_MTIMECMP, 32'h1234_5678);
        read_csr(`CSR_MTIMECMP, val);
        check_xlen("mtimecmp", 32'h1234_5678, val);
        // low bits of mtvec are hardwired to zero
        write_csr(`CSR_MTVEC, 32'h0000_3003);
        read_csr(`CSR_MTVEC, val);
        check_xlen("mtvec", 32'h0000_3000, val);
    endtask

    initial begin
        seed      = 32'h935;
        errors    = 0;
        rst_n     = 1'b0;
        ex_status = '0;
        sw_wr     = '0;
        csr_raddr = '0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        reset_state();
        ecall_trap();
        cause_priority();
        mret_return();
        timer_interrupt();
        irq_over_ecall();
        sw_roundtrip();

        assert_fails = u_dut.u_trap_ctrl.u_asserts.assert_fails;
        $display("errors: %0d, assertion failures: %0d", errors, assert_fails);
        if ((errors == 0) && (assert_fails == 0)) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== trap_unit_top.sv ====
`include "trap_config.svh"

module trap_unit_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  trap_pkg::ex_status_t ex_status_i,
    input  trap_pkg::csr_wr_t    sw_wr_i,
    input  trap_pkg::csr_addr_t  csr_raddr_i,
    output trap_pkg::xlen_t      csr_rdata_o,
    output logic                 stall_o,
    output trap_pkg::redirect_t  redirect_o
);
    import trap_pkg::*;

    logic    timer_pending;
    xlen_t   timer_rdata;
    xlen_t   csr_rdata;
    xlen_t   mtvec;
    xlen_t   mepc;
    xlen_t   mstatus;
    csr_wr_t trap_wr;

    mtimer u_mtimer (
        .clk             (clk),
        .rst_n           (rst_n),
        .sw_wr_i         (sw_wr_i),
        .raddr_i         (csr_raddr_i),
        .rdata_o         (timer_rdata),
        .timer_pending_o (timer_pending)
    );

    csr_file u_csr_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .trap_wr_i (trap_wr),
        .sw_wr_i   (sw_wr_i),
        .raddr_i   (csr_raddr_i),
        .rdata_o   (csr_rdata),
        .mtvec_o   (mtvec),
        .mepc_o    (mepc),
        .mstatus_o (mstatus)
    );

    trap_ctrl u_trap_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .ex_status_i     (ex_status_i),
        .timer_pending_i (timer_pending),
        .mtvec_i         (mtvec),
        .mepc_i          (mepc),
        .mstatus_i       (mstatus),
        .trap_wr_o       (trap_wr),
        .redirect_o      (redirect_o),
        .stall_o         (stall_o)
    );

    // mtimecmp lives in the timer, everything else in the csr file
    assign csr_rdata_o = (csr_raddr_i == `CSR_MTIMECMP) ? timer_rdata : csr_rdata;

endmodule
